//--- flist.f
source/display_pkg.sv
source/bram_sdp.sv
source/display_timing.sv
source/fb_row_fetch.sv
source/linebuffer.sv
source/pixel_out.sv
source/scaled_display.sv
bench/scaled_display_tb.sv

//--- Bender.yml
package:
  name: scaled_display

sources:
  - files:
      - source/display_pkg.sv
      - source/bram_sdp.sv
      - source/display_timing.sv
      - source/fb_row_fetch.sv
      - source/linebuffer.sv
      - source/pixel_out.sv
      - source/scaled_display.sv
  - target: simulation
    files:
      - bench/scaled_display_tb.sv

//--- bench/scaled_display_tb.sv
/* Testbench for the scaled display: loads image and palette for each table case,
   then checks sync and every pixel of one full frame against its own model. */

`timescale 1ns/1ns

module scaled_display_tb
    import display_pkg::*;
();

    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;  // cycles per frame
    localparam int NCASES    = 3;
    localparam int RAMP      = 0;  // palette patterns
    localparam int INV_RAMP  = 1;
    localparam int COLUMN    = 0;  // image patterns
    localparam int ROW       = 1;
    localparam int RANDOM    = 2;  // shared by both

    logic             clk_sys, rst;
    logic             fb_we, pal_we;
    fb_addr_t         fb_waddr;
    cidx_t            fb_wdata;
    cidx_t            pal_waddr;
    colr_t            pal_wdata;
    logic             hsync, vsync;
    logic [CHANW-1:0] vga_r, vga_g, vga_b;

    int    pal_sel [NCASES];  // case table, palette column
    int    img_sel [NCASES];  // case table, image column
    cidx_t img_ref [FB_PIXELS];
    colr_t pal_ref [2**CIDXW];
    int    cyc;               // cycles since reset release
    logic  check_img;         // image pixels compared only in the checked frame

    scaled_display dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;  // 4 ns period
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [11:0] got,
                                input logic [11:0] exp);
        report_failure($sformatf("Error: %s = %h, expected %h at cycle %0d",
                                 name, got, exp, cyc));
    endtask

    // output cycle c shows counter position c - PIX_LAT, idle before that
    task automatic check_outputs(input int c);
        int    p, x, y;
        logic  exp_hs, exp_vs, in_img;
        colr_t exp_c;
        exp_hs = 1'b1;
        exp_vs = 1'b1;
        in_img = 1'b0;
        exp_c  = '0;  // black in border and blanking
        if (c >= PIX_LAT) begin
            p      = c - PIX_LAT;
            x      = p % H_TOTAL;
            y      = (p / H_TOTAL) % V_TOTAL;
            exp_hs = !((x >= H_SYNC_START) && (x < H_SYNC_END));
            exp_vs = !((y >= V_SYNC_START) && (y < V_SYNC_END));
            in_img = (x < FB_WIDTH * FB_SCALE) && (y < FB_HEIGHT * FB_SCALE);
            if (in_img)
                exp_c = pal_ref[img_ref[(y / FB_SCALE) * FB_WIDTH + x / FB_SCALE]];
        end
        assert (hsync === exp_hs) else report_value("hsync", hsync, exp_hs);
        assert (vsync === exp_vs) else report_value("vsync", vsync, exp_vs);
        if (!in_img || check_img) begin
            assert (vga_r === exp_c[11:8]) else report_value("vga_r", vga_r, exp_c[11:8]);
            assert (vga_g === exp_c[7:4])  else report_value("vga_g", vga_g, exp_c[7:4]);
            assert (vga_b === exp_c[3:0])  else report_value("vga_b", vga_b, exp_c[3:0]);
        end
    endtask

    // one clock, outputs sampled 1 ns after the edge
    task automatic step();
        @(posedge clk_sys);
        #1;
        cyc++;
        check_outputs(cyc);
    endtask

    function automatic colr_t pal_pattern(input int sel, input int i);
        cidx_t k;
        k = (sel == INV_RAMP) ? cidx_t'(15 - i) : cidx_t'(i);
        if (sel == RANDOM)
            return colr_t'($urandom);
        return {k, k + 4'd5, k + 4'd10};  // channels offset so swaps show
    endfunction

    function automatic cidx_t img_pattern(input int sel, input int addr);
        case (sel)
            COLUMN:  return cidx_t'(addr % FB_WIDTH);
            ROW:     return cidx_t'(addr / FB_WIDTH);
            default: return cidx_t'($urandom);
        endcase
    endfunction

    // fills model and DUT memories, one write per cycle
    task automatic load_case(input int psel, input int isel);
        for (int a = 0; a < FB_PIXELS; a++) begin
            img_ref[a] = img_pattern(isel, a);
            fb_we      = 1'b1;
            fb_waddr   = fb_addr_t'(a);
            fb_wdata   = img_ref[a];
            step();
        end
        fb_we = 1'b0;
        for (int i = 0; i < 2**CIDXW; i++) begin
            pal_ref[i] = pal_pattern(psel, i);
            pal_we     = 1'b1;
            pal_waddr  = cidx_t'(i);
            pal_wdata  = pal_ref[i];
            step();
        end
        pal_we = 1'b0;
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        while ((cyc % FRAME_CYC) != 0) begin  // model counters at 0,0
            if (n > FRAME_CYC)
                report_failure("timeout while waiting for the start of a frame");
            step();
            n++;
        end
    endtask

    initial begin
        void'($urandom(32'ha07f_da86));
        rst       = 1'b1;
        fb_we     = 1'b0;
        fb_waddr  = '0;
        fb_wdata  = '0;
        pal_we    = 1'b0;
        pal_waddr = '0;
        pal_wdata = '0;
        check_img = 1'b0;
        cyc       = 0;
        pal_sel   = '{RAMP, INV_RAMP, RANDOM};
        img_sel   = '{COLUMN, ROW, RANDOM};
        repeat (5) begin
            @(posedge clk_sys);
            #1;
            check_outputs(0);  // idle levels in reset
        end
        rst = 1'b0;  // counters 0,0 in this cycle
        for (int k = 0; k < NCASES; k++) begin
            load_case(pal_sel[k], img_sel[k]);
            wait_frame_start();
            repeat (FRAME_CYC) step();     // frame still mixing old rows
            repeat (PIX_LAT - 1) step();
            check_img = 1'b1;              // next step shows pixel 0,0
            repeat (FRAME_CYC) step();
            check_img = 1'b0;
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- source/scaled_display.sv
/* Top of the scaled framebuffer display. Framebuffer and palette are loaded
   through their write ports; the panel gets sync and 4-bit RGB at one pixel/cycle. */

`timescale 1ns/1ns

module scaled_display
    import display_pkg::*;
(
    input  logic             clk_sys,
    input  logic             rst,
    input  logic             fb_we,      // framebuffer write
    input  fb_addr_t         fb_waddr,
    input  cidx_t            fb_wdata,
    input  logic             pal_we,     // palette write
    input  cidx_t            pal_waddr,
    input  colr_t            pal_wdata,
    output logic             hsync,
    output logic             vsync,
    output logic [CHANW-1:0] vga_r,
    output logic [CHANW-1:0] vga_g,
    output logic [CHANW-1:0] vga_b
);

    coord_t   sx, sy;
    logic     de, hsync_raw, vsync_raw;
    logic     line;
    fb_addr_t fb_raddr;
    cidx_t    fb_cidx;
    logic     lb_we;
    lb_addr_t lb_waddr;
    cidx_t    lb_wdata;
    logic     row_done;
    cidx_t    lb_cidx;   // index for current pixel
    colr_t    colr;      // palette colour

    display_timing u_timing (
        .clk_sys, .rst, .sx, .sy, .de, .hsync_raw, .vsync_raw, .line, .frame ()
    );

    fb_row_fetch u_fetch (
        .clk_sys, .rst, .line, .sy, .fb_raddr, .fb_cidx,
        .lb_we, .lb_waddr, .lb_wdata, .row_done
    );

    bram_sdp #(.data_t(cidx_t), .DEPTH(FB_PIXELS)) u_fb (
        .clk_sys,
        .we         (fb_we),
        .addr_write (fb_waddr),
        .data_in    (fb_wdata),
        .addr_read  (fb_raddr),
        .data_out   (fb_cidx)
    );

    linebuffer u_lb (
        .clk_sys, .rst, .line, .row_done, .lb_we, .lb_waddr, .lb_wdata, .sx, .lb_cidx
    );

    // one palette entry per colour index
    bram_sdp #(.data_t(colr_t), .DEPTH(2**CIDXW)) u_pal (
        .clk_sys,
        .we         (pal_we),
        .addr_write (pal_waddr),
        .data_in    (pal_wdata),
        .addr_read  (lb_cidx),
        .data_out   (colr)
    );

    pixel_out u_out (
        .clk_sys, .rst, .sx, .sy, .de, .hsync_raw, .vsync_raw, .colr,
        .hsync, .vsync, .vga_r, .vga_g, .vga_b
    );

endmodule

//--- source/pixel_out.sv
/* Panel output stage: delays sync, enable and paint area to line up with the
   palette colour, blanks outside the image and registers the panel pins. */

`timescale 1ns/1ns

module pixel_out
    import display_pkg::*;
(
    input  logic             clk_sys,
    input  logic             rst,
    input  coord_t           sx,
    input  coord_t           sy,
    input  logic             de,
    input  logic             hsync_raw,
    input  logic             vsync_raw,
    input  colr_t            colr,    // two cycles behind sx
    output logic             hsync,
    output logic             vsync,
    output logic [CHANW-1:0] vga_r,
    output logic [CHANW-1:0] vga_g,
    output logic [CHANW-1:0] vga_b
);

    logic                 paint;      // inside scaled image
    logic [PIX_LAT-2:0]   hs_dly;     // first stages of delay line
    logic [PIX_LAT-2:0]   vs_dly;
    logic [PIX_LAT-2:0]   de_dly;
    logic [PIX_LAT-2:0]   paint_dly;
    logic                 show;       // colour allowed this cycle

    assign paint = (sx < FB_WIDTH * FB_SCALE) && (sy < FB_HEIGHT * FB_SCALE);
    assign show  = de_dly[PIX_LAT-2] && paint_dly[PIX_LAT-2];

    // output register is the last of the PIX_LAT stages
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hs_dly    <= '1;  // sync idle high
            vs_dly    <= '1;
            de_dly    <= '0;
            paint_dly <= '0;
            hsync     <= 1'b1;
            vsync     <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            hs_dly    <= {hs_dly[PIX_LAT-3:0], hsync_raw};
            vs_dly    <= {vs_dly[PIX_LAT-3:0], vsync_raw};
            de_dly    <= {de_dly[PIX_LAT-3:0], de};
            paint_dly <= {paint_dly[PIX_LAT-3:0], paint};
            hsync     <= hs_dly[PIX_LAT-2];
            vsync     <= vs_dly[PIX_LAT-2];
            vga_r     <= show ? colr[3*CHANW-1:2*CHANW] : '0;  // black in border
            vga_g     <= show ? colr[2*CHANW-1:CHANW]   : '0;
            vga_b     <= show ? colr[CHANW-1:0]         : '0;
        end
    end

endmodule

//--- source/linebuffer.sv
/* Ping-pong linebuffer: one bank fills from the fetcher while the other is shown.
   Display reads map screen column to buffer column for horizontal scaling. */

`timescale 1ns/1ns

module linebuffer
    import display_pkg::*;
(
    input  logic     clk_sys,
    input  logic     rst,
    input  logic     line,      // line start, swaps display bank
    input  logic     row_done,  // fill finished, swaps write bank
    input  logic     lb_we,
    input  lb_addr_t lb_waddr,
    input  cidx_t    lb_wdata,
    input  coord_t   sx,
    output cidx_t    lb_cidx    // one cycle after sx
);

    logic     wr_bank;    // bank being filled
    logic     done_bank;  // last completed bank
    logic     disp_bank;  // bank on screen
    lb_addr_t rd_col;     // scaled read column
    cidx_t    q0, q1;     // bank read data

    // bank select state
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            wr_bank   <= 1'b0;
            done_bank <= 1'b1;
            disp_bank <= 1'b1;
        end else begin
            if (row_done) begin
                done_bank <= wr_bank;
                wr_bank   <= !wr_bank;
            end
            if (line) begin
                disp_bank <= done_bank;  // take effect from column 1
            end
        end
    end

    // x / scale, off-image columns fold but are never painted
    assign rd_col = lb_addr_t'(sx / FB_SCALE);

    bram_sdp #(.data_t(cidx_t), .DEPTH(FB_WIDTH)) u_bank0 (
        .clk_sys,
        .we         (lb_we && !wr_bank),
        .addr_write (lb_waddr),
        .data_in    (lb_wdata),
        .addr_read  (rd_col),
        .data_out   (q0)
    );

    bram_sdp #(.data_t(cidx_t), .DEPTH(FB_WIDTH)) u_bank1 (
        .clk_sys,
        .we         (lb_we && wr_bank),
        .addr_write (lb_waddr),
        .data_in    (lb_wdata),
        .addr_read  (rd_col),
        .data_out   (q1)
    );

    // column 0 data arrives after the bank swap
    assign lb_cidx = disp_bank ? q1 : q0;

endmodule

//--- source/fb_row_fetch.sv
/* Framebuffer row fetcher: at each line start, checks whether the next line begins
   a new scaled row and, if so, streams that fb row into the linebuffer. */

`timescale 1ns/1ns

module fb_row_fetch
    import display_pkg::*;
(
    input  logic     clk_sys,
    input  logic     rst,
    input  logic     line,      // line start strobe
    input  coord_t   sy,
    output fb_addr_t fb_raddr,  // framebuffer read address
    input  cidx_t    fb_cidx,   // fb data, one cycle after fb_raddr
    output logic     lb_we,
    output lb_addr_t lb_waddr,
    output cidx_t    lb_wdata,
    output logic     row_done   // cycle after last lb write
);

    coord_t   next_line;  // line after the current one
    logic     need_row;   // next line starts a new fb row
    logic     busy;       // issuing reads
    lb_addr_t col;        // read column
    fb_addr_t row_base;   // first fb address of the row
    lb_addr_t wcol;       // column of returning data

    always_comb begin
        next_line = (sy == coord_t'(V_TOTAL - 1)) ? '0 : sy + 1'b1;
        need_row  = (next_line < FB_HEIGHT * FB_SCALE) && (next_line % FB_SCALE == 0);
    end

    assign fb_raddr = row_base + fb_addr_t'(col);  // base plus column

    // read side, FB_WIDTH consecutive addresses
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            busy <= 1'b0;
            col  <= '0;
        end else if (busy) begin
            col  <= col + 1'b1;
            busy <= (col != lb_addr_t'(FB_WIDTH - 1));  // stop after last column
        end else if (line && need_row) begin
            busy <= 1'b1;
            col  <= '0;
        end
    end

    // row base held for the whole burst
    always_ff @(posedge clk_sys) begin
        if (!busy && line && need_row) begin
            row_base <= fb_addr_t'((next_line / FB_SCALE) * FB_WIDTH);
        end
    end

    // write side trails reads by the fb latency
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            lb_we    <= 1'b0;
            row_done <= 1'b0;
        end else begin
            lb_we    <= busy;
            row_done <= lb_we && (wcol == lb_addr_t'(FB_WIDTH - 1));
        end
        wcol <= col;  // payload, follows the read
    end

    assign lb_waddr = wcol;
    assign lb_wdata = fb_cidx;  // memory output is already registered

endmodule

//--- source/display_timing.sv
/* Frame timing for the small panel mode: column and line counters plus decoded
   sync, data enable and the line and frame start strobes. */

`timescale 1ns/1ns

module display_timing
    import display_pkg::*;
(
    input  logic   clk_sys,
    input  logic   rst,
    output coord_t sx,         // current column
    output coord_t sy,         // current line
    output logic   de,         // inside visible area
    output logic   hsync_raw,  // active low, undelayed
    output logic   vsync_raw,  // active low, undelayed
    output logic   line,       // one cycle at column 0
    output logic   frame       // one cycle at 0,0
);

    logic last_col;  // end of line reached
    logic last_line;

    assign last_col  = (sx == coord_t'(H_TOTAL - 1));
    assign last_line = (sy == coord_t'(V_TOTAL - 1));

    // free-running counters, 0,0 straight after reset
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else begin
            if (last_col) begin
                sx <= '0;
                sy <= last_line ? '0 : sy + 1'b1;  // wrap at V_TOTAL
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

    // decode from current counts
    always_comb begin
        de        = (sx < H_ACTIVE) && (sy < V_ACTIVE);
        hsync_raw = !((sx >= H_SYNC_START) && (sx < H_SYNC_END));
        vsync_raw = !((sy >= V_SYNC_START) && (sy < V_SYNC_END));
        line      = (sx == '0);
        frame     = (sx == '0) && (sy == '0);
    end

endmodule

//--- source/bram_sdp.sv
/* Simple dual-port inferred memory, one write port and one registered read port.
   Payload type and depth are parameters; used for framebuffer, linebuffer, palette. */

`timescale 1ns/1ns

module bram_sdp #(
    parameter type data_t = logic [7:0],  // stored payload
    parameter int  DEPTH  = 256           // number of entries
) (
    input  logic                     clk_sys,
    input  logic                     we,          // write strobe
    input  logic [$clog2(DEPTH)-1:0] addr_write,
    input  data_t                    data_in,
    input  logic [$clog2(DEPTH)-1:0] addr_read,
    output data_t                    data_out     // valid cycle after addr_read
);

    data_t mem [DEPTH];  // storage array, no init

    // write lands at the edge, visible to reads from next cycle
    always_ff @(posedge clk_sys) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
    end

    // read-during-write returns old contents
    always_ff @(posedge clk_sys) begin
        data_out <= mem[addr_read];
    end

endmodule

//--- source/display_pkg.sv
/* Shared geometry, framebuffer sizing and pixel types for the scaled display.
   Modules pull these in with a wildcard import in their header. */

package display_pkg;

    // horizontal timing, in pixel columns
    localparam int H_ACTIVE     = 40;  // visible columns
    localparam int H_SYNC_START = 44;  // first hsync column
    localparam int H_SYNC_END   = 48;  // first column after hsync
    localparam int H_TOTAL      = 52;  // columns per line

    // vertical timing, in lines
    localparam int V_ACTIVE     = 30;  // visible lines
    localparam int V_SYNC_START = 31;  // first vsync line
    localparam int V_SYNC_END   = 33;
    localparam int V_TOTAL      = 34;  // lines per frame

    // framebuffer
    localparam int FB_WIDTH  = 16;  // pixels per fb row
    localparam int FB_HEIGHT = 12;  // fb rows
    localparam int FB_SCALE  = 2;   // same factor both directions
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;

    // colour widths
    localparam int CIDXW = 4;  // bits per colour index
    localparam int CHANW = 4;  // bits per channel

    // counter to panel: lb read, palette read, output reg
    localparam int PIX_LAT = 3;

    typedef logic [5:0]         coord_t;    // screen x or y
    typedef logic [7:0]         fb_addr_t;  // covers FB_PIXELS
    typedef logic [3:0]         lb_addr_t;  // covers FB_WIDTH
    typedef logic [CIDXW-1:0]   cidx_t;
    // red in top nibble, then green, then blue
    typedef logic [3*CHANW-1:0] colr_t;

endpackage
